// File: icache.f
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/icache_mem_model.sv
tb/icache_tb.sv

// File: src/icache_ctrl.sv
// icache controller
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter  int INDEX_WIDTH = 6,
  localparam int TAG_WIDTH   = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
  input  logic                   i_clk,
  input  logic                   i_rst,
  // cpu side
  input  logic                   i_valid,
  input  icache_pkg::addr_t      i_addr,
  output logic                   o_addr_ok,
  output logic                   o_data_ok,
  output icache_pkg::word_t      o_rdata,
  // bus side
  output logic                   o_rd_req,
  output icache_pkg::addr_t      o_rd_addr,
  input  logic                   i_rd_rdy,
  input  icache_pkg::ret_beat_t  i_ret,
  // arrays
  input  logic                   i_hit,
  input  logic                   i_hit_way,
  input  logic                   i_victim_way,
  input  icache_pkg::word_t      i_way0_word,
  input  icache_pkg::word_t      i_way1_word,
  output logic [INDEX_WIDTH-1:0] o_rd_index,
  output logic [INDEX_WIDTH-1:0] o_req_index,
  output logic [TAG_WIDTH-1:0]   o_req_tag,
  output icache_pkg::word_sel_t  o_word_sel,
  output icache_pkg::line_wr_t   o_line_wr,
  output logic                   o_fill,
  output logic                   o_fill_way
);

  localparam int OFS = icache_pkg::OFFSET_WIDTH;

  icache_pkg::cache_state_e state_q;
  icache_pkg::cache_state_e state_d;
  icache_pkg::addr_t        req_addr_q;  // request buffer
  icache_pkg::word_sel_t    beat_cnt_q;
  logic                     victim_q;
  logic                     in_lookup;
  logic                     in_refill;
  logic                     beat;

  assign in_lookup = (state_q == icache_pkg::LOOKUP);
  assign in_refill = (state_q == icache_pkg::REFILL);
  assign beat      = in_refill && i_ret.valid;

  // --------------------
  // request buffer
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      req_addr_q <= '0;
    end else if (i_valid && o_addr_ok) begin
      req_addr_q <= i_addr;
    end
  end

  assign o_req_tag   = req_addr_q[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
  assign o_req_index = req_addr_q[OFS +: INDEX_WIDTH];
  assign o_word_sel  = req_addr_q[OFS-1 -: icache_pkg::WORD_SEL_WIDTH];
  assign o_rd_index  = o_addr_ok ? i_addr[OFS +: INDEX_WIDTH] : o_req_index;

  // --------------------
  // state machine
  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::IDLE: begin
        if (i_valid) begin
          state_d = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        if (!i_hit) begin
          state_d = icache_pkg::MISS;
        end else if (!i_valid) begin
          state_d = icache_pkg::IDLE;  // otherwise stay for the next hit
        end
      end
      icache_pkg::MISS: begin
        if (i_rd_rdy) begin
          state_d = icache_pkg::REFILL;
        end
      end
      default: begin
        if (beat && i_ret.last) begin
          state_d = icache_pkg::IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q    <= icache_pkg::IDLE;
      beat_cnt_q <= '0;
      victim_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (in_lookup && !i_hit) begin
        victim_q <= i_victim_way;  // held through the refill
      end
      if (o_rd_req && i_rd_rdy) begin
        beat_cnt_q <= '0;
      end else if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // --------------------
  // outputs
  assign o_addr_ok = (state_q == icache_pkg::IDLE) || (in_lookup && i_hit && i_valid);
  assign o_data_ok = (in_lookup && i_hit) || (beat && (beat_cnt_q == o_word_sel));
  assign o_rdata   = in_lookup ? (i_hit_way ? i_way1_word : i_way0_word) : i_ret.data;

  assign o_rd_req  = (state_q == icache_pkg::MISS);
  assign o_rd_addr = {req_addr_q[icache_pkg::ADDR_WIDTH-1:OFS], {OFS{1'b0}}};

  assign o_line_wr.en       = beat;
  assign o_line_wr.way      = victim_q;
  assign o_line_wr.word_sel = beat_cnt_q;
  assign o_line_wr.data     = i_ret.data;

  assign o_fill     = beat && i_ret.last;
  assign o_fill_way = victim_q;

  // address held with the request
  a_req_held : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rd_req && !i_rd_rdy) |=> (o_rd_req && $stable(o_rd_addr)));

  // bus must deliver exactly four beats
  a_last_on_word3 : assert property (@(posedge i_clk) disable iff (i_rst)
    (beat && i_ret.last) |->
      (beat_cnt_q == icache_pkg::word_sel_t'(icache_pkg::LINE_WORDS - 1)));

endmodule

`default_nettype wire

// File: src/icache_data_array.sv
// icache line storage
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                      i_clk,
  input  logic [INDEX_WIDTH-1:0]    i_rd_index,
  input  logic [INDEX_WIDTH-1:0]    i_wr_index,
  input  icache_pkg::line_wr_t      i_line_wr,
  input  icache_pkg::word_sel_t     i_word_sel,  // from the request buffer
  output icache_pkg::word_t         o_way0_word,
  output icache_pkg::word_t         o_way1_word
);

  localparam int SETS  = 1 << INDEX_WIDTH;
  localparam int WORDS = icache_pkg::LINE_WORDS;

  icache_pkg::word_t line_mem [2][SETS][WORDS];
  icache_pkg::word_t rd_line  [2][WORDS];  // registered read line

  // --------------------
  // refill write, one word per beat
  always_ff @(posedge i_clk) begin
    if (i_line_wr.en) begin
      line_mem[i_line_wr.way][i_wr_index][i_line_wr.word_sel] <= i_line_wr.data;
    end
  end

  // --------------------
  // synchronous read of both ways
  always_ff @(posedge i_clk) begin
    for (int w = 0; w < 2; w++) begin
      for (int k = 0; k < WORDS; k++) begin
        rd_line[w][k] <= line_mem[w][i_rd_index][k];
      end
    end
  end

  assign o_way0_word = rd_line[0][i_word_sel];
  assign o_way1_word = rd_line[1][i_word_sel];

endmodule

`default_nettype wire

// File: src/icache_pkg.sv
// icache shared definitions
`default_nettype none

package icache_pkg;

  // --------------------
  // widths
  localparam int ADDR_WIDTH     = 32;
  localparam int WORD_WIDTH     = 64;  // fetch word and bus beat
  localparam int LINE_WORDS     = 4;
  localparam int WORD_SEL_WIDTH = 2;
  localparam int OFFSET_WIDTH   = 5;   // 32-byte line

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [WORD_WIDTH-1:0]     word_t;
  typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;

  // --------------------
  // bus return beat and refill write
  typedef struct packed {
    logic  valid;
    logic  last;   // set on word 3
    word_t data;
  } ret_beat_t;

  typedef struct packed {
    logic      en;
    logic      way;
    word_sel_t word_sel;
    word_t     data;
  } line_wr_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    MISS,
    REFILL
  } cache_state_e;

endpackage

`default_nettype wire

// File: src/icache_tag_array.sv
// icache tag and valid store
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
  parameter  int INDEX_WIDTH = 6,
  localparam int TAG_WIDTH   = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [INDEX_WIDTH-1:0] i_index,      // buffered set index
  input  logic [TAG_WIDTH-1:0]   i_tag,        // buffered tag
  input  logic                   i_fill,       // last refill beat
  input  logic                   i_fill_way,
  output logic                   o_hit,
  output logic                   o_hit_way,
  output logic                   o_victim_way
);

  localparam int SETS = 1 << INDEX_WIDTH;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  tag_t            tag_mem [2][SETS];
  logic [SETS-1:0] valid_q [2];
  logic            rep_q;      // way to evict when both are valid
  logic [1:0]      way_valid;
  logic [1:0]      way_hit;

  // --------------------
  // compare both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_valid[w] = valid_q[w][i_index];
      way_hit[w]   = way_valid[w] && (tag_mem[w][i_index] == i_tag);
    end
  end

  assign o_hit     = |way_hit;
  assign o_hit_way = way_hit[1];

  // empty way first, then the replacement bit
  always_comb begin
    if (!way_valid[0]) begin
      o_victim_way = 1'b0;
    end else if (!way_valid[1]) begin
      o_victim_way = 1'b1;
    end else begin
      o_victim_way = rep_q;
    end
  end

  // --------------------
  // fill on the last beat
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      rep_q      <= 1'b0;
    end else if (i_fill) begin
      valid_q[i_fill_way][i_index] <= 1'b1;
      if (valid_q[i_fill_way][i_index]) begin
        rep_q <= ~rep_q;  // flips only when a valid line left
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill) begin
      tag_mem[i_fill_way][i_index] <= i_tag;
    end
  end

  // a line is only filled after missing in both ways
  a_one_way_hit : assert property (@(posedge i_clk) disable iff (i_rst)
    !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

// File: src/icache_top.sv
// two-way instruction cache
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  icache_pkg::addr_t     i_addr,
  output logic                  o_addr_ok,
  output logic                  o_data_ok,
  output icache_pkg::word_t     o_rdata,
  output logic                  o_rd_req,
  output icache_pkg::addr_t     o_rd_addr,
  input  logic                  i_rd_rdy,
  input  icache_pkg::ret_beat_t i_ret
);

  localparam int TAG_WIDTH = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH;

  logic                  hit;
  logic                  hit_way;
  logic                  victim_way;
  icache_pkg::word_t     way0_word;
  icache_pkg::word_t     way1_word;
  logic [INDEX_WIDTH-1:0] rd_index;
  logic [INDEX_WIDTH-1:0] req_index;
  logic [TAG_WIDTH-1:0]  req_tag;
  icache_pkg::word_sel_t word_sel;
  icache_pkg::line_wr_t  line_wr;
  logic                  fill;
  logic                  fill_way;

  icache_ctrl #(
    .INDEX_WIDTH (INDEX_WIDTH)
  ) u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_addr       (i_addr),
    .o_addr_ok    (o_addr_ok),
    .o_data_ok    (o_data_ok),
    .o_rdata      (o_rdata),
    .o_rd_req     (o_rd_req),
    .o_rd_addr    (o_rd_addr),
    .i_rd_rdy     (i_rd_rdy),
    .i_ret        (i_ret),
    .i_hit        (hit),
    .i_hit_way    (hit_way),
    .i_victim_way (victim_way),
    .i_way0_word  (way0_word),
    .i_way1_word  (way1_word),
    .o_rd_index   (rd_index),
    .o_req_index  (req_index),
    .o_req_tag    (req_tag),
    .o_word_sel   (word_sel),
    .o_line_wr    (line_wr),
    .o_fill       (fill),
    .o_fill_way   (fill_way)
  );

  icache_tag_array #(
    .INDEX_WIDTH (INDEX_WIDTH)
  ) u_tag_array (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_index      (req_index),
    .i_tag        (req_tag),
    .i_fill       (fill),
    .i_fill_way   (fill_way),
    .o_hit        (hit),
    .o_hit_way    (hit_way),
    .o_victim_way (victim_way)
  );

  icache_data_array #(
    .INDEX_WIDTH (INDEX_WIDTH)
  ) u_data_array (
    .i_clk       (i_clk),
    .i_rd_index  (rd_index),
    .i_wr_index  (req_index),  // refill goes to the buffered set
    .i_line_wr   (line_wr),
    .i_word_sel  (word_sel),
    .o_way0_word (way0_word),
    .o_way1_word (way1_word)
  );

endmodule

`default_nettype wire

// File: tb/icache_mem_model.sv
// icache testbench memory
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model (
  input  logic                  i_clk,
  input  logic                  i_rd_req,
  input  icache_pkg::addr_t     i_rd_addr,
  output logic                  o_rd_rdy,
  output icache_pkg::ret_beat_t o_ret
);

  integer            seed;
  int                delay;
  int                gap;
  icache_pkg::addr_t line_addr;

  // inverted word address on top, word address below
  function automatic icache_pkg::word_t beat_data(input icache_pkg::addr_t a);
    icache_pkg::addr_t w;
    w = {a[icache_pkg::ADDR_WIDTH-1:3], 3'b000};
    return {~w, w};
  endfunction

  // --------------------
  // line read responder
  initial begin
    seed     = 27;
    o_rd_rdy = 1'b0;
    o_ret    = '0;
    forever begin
      @(negedge i_clk);
      if (i_rd_req) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge i_clk);  // 0 to 3 cycles before ready
        o_rd_rdy  = 1'b1;
        line_addr = i_rd_addr;
        @(negedge i_clk);
        o_rd_rdy = 1'b0;
        for (int k = 0; k < icache_pkg::LINE_WORDS; k++) begin
          gap = $unsigned($random(seed)) % 3;
          repeat (gap) @(negedge i_clk);  // beat gap
          o_ret.valid = 1'b1;
          o_ret.last  = (k == icache_pkg::LINE_WORDS - 1);
          o_ret.data  = beat_data(line_addr + icache_pkg::addr_t'(k * 8));
          @(negedge i_clk);
          o_ret = '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/icache_tb.sv
// icache testbench
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int SAMPLE_DELAY   = CLK_PERIOD / 4;
  localparam int RESET_CYCLES   = 3;
  localparam int INDEX_WIDTH    = 6;
  localparam int OFS            = icache_pkg::OFFSET_WIDTH;
  localparam int TAG_WIDTH      = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFS;
  localparam int SETS           = 1 << INDEX_WIDTH;
  localparam int NUM_REQS       = 20;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 20;

  typedef struct packed {
    icache_pkg::addr_t addr;
    logic              hit;    // predicted by the reference model
    logic [31:0]       cycle;  // acceptance cycle
  } pending_t;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_valid;
  icache_pkg::addr_t     i_addr;
  logic                  o_addr_ok;
  logic                  o_data_ok;
  icache_pkg::word_t     o_rdata;
  logic                  o_rd_req;
  icache_pkg::addr_t     o_rd_addr;
  logic                  i_rd_rdy;
  icache_pkg::ret_beat_t i_ret;

  int                   cycle_count;
  int                   error_count;
  int                   idx;
  logic                 req_seen;   // bus request seen for the oldest request
  pending_t             pend_q[$];
  logic                 ref_valid [SETS][2];
  logic [TAG_WIDTH-1:0] ref_tag   [SETS][2];
  logic                 ref_rep;

  // cold misses at word selectors 0..3, hits, then three lines in set 5
  icache_pkg::addr_t req_table [NUM_REQS] = '{
    32'h0000_1000, 32'h0000_1048, 32'h0000_1090, 32'h0000_10D8,
    32'h0000_1008, 32'h0000_1010, 32'h0000_1018, 32'h0000_1040,
    32'h0000_1098, 32'h0000_10D0, 32'h0000_20A8, 32'h0000_28B0,
    32'h0000_30B8, 32'h0000_28A0, 32'h0000_20A0, 32'h0000_30A0,
    32'h0000_28A8, 32'h0000_20B8, 32'h8765_4FE0, 32'h8765_4FF8
  };

  icache_top #(
    .INDEX_WIDTH (INDEX_WIDTH)
  ) dut0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_valid),
    .i_addr    (i_addr),
    .o_addr_ok (o_addr_ok),
    .o_data_ok (o_data_ok),
    .o_rdata   (o_rdata),
    .o_rd_req  (o_rd_req),
    .o_rd_addr (o_rd_addr),
    .i_rd_rdy  (i_rd_rdy),
    .i_ret     (i_ret)
  );

  icache_mem_model u_mem (
    .i_clk     (i_clk),
    .i_rd_req  (o_rd_req),
    .i_rd_addr (o_rd_addr),
    .o_rd_rdy  (i_rd_rdy),
    .o_ret     (i_ret)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    stop_run("timeout: the request table did not complete in time");
  end

  // --------------------
  // expected values
  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
    icache_pkg::addr_t w;
    w = {a[icache_pkg::ADDR_WIDTH-1:3], 3'b000};
    return {~w, w};
  endfunction

  function automatic icache_pkg::addr_t line_address(input icache_pkg::addr_t a);
    return {a[icache_pkg::ADDR_WIDTH-1:OFS], {OFS{1'b0}}};
  endfunction

  task automatic stop_run(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      stop_run("value mismatch");
    end
  endtask

  // hit or miss, then the fill that a miss causes
  task automatic accept_request(input icache_pkg::addr_t a);
    pending_t             entry;
    int                   set_idx;
    logic [TAG_WIDTH-1:0] tag;
    logic                 way;
    set_idx     = a[OFS +: INDEX_WIDTH];
    tag         = a[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    entry.addr  = a;
    entry.cycle = cycle_count;
    entry.hit   = (ref_valid[set_idx][0] && ref_tag[set_idx][0] == tag) ||
                  (ref_valid[set_idx][1] && ref_tag[set_idx][1] == tag);
    if (!entry.hit) begin
      if (!ref_valid[set_idx][0]) begin
        way = 1'b0;
      end else if (!ref_valid[set_idx][1]) begin
        way = 1'b1;
      end else begin
        way     = ref_rep;
        ref_rep = ~ref_rep;  // a valid line was evicted
      end
      ref_valid[set_idx][way] = 1'b1;
      ref_tag[set_idx][way]   = tag;
    end
    pend_q.push_back(entry);
  endtask

  task automatic check_request();
    if (pend_q.size() == 0) begin
      stop_run("o_rd_req went high with no request in flight");
    end else begin
      compare("o_rd_addr", o_rd_addr, line_address(pend_q[0].addr));
      compare("o_addr_ok", o_addr_ok, 1'b0);  // no acceptance while missing
      req_seen = 1'b1;
    end
  endtask

  task automatic check_response();
    pending_t entry;
    if (pend_q.size() == 0) begin
      stop_run("o_data_ok pulsed with no request in flight");
    end else begin
      entry = pend_q.pop_front();
      compare("o_rdata", o_rdata, expected_word(entry.addr));
      compare("o_rd_req seen", req_seen, !entry.hit);
      if (entry.hit) begin
        compare("o_data_ok cycle", cycle_count, entry.cycle + 1);  // one cycle after accept
      end
      req_seen = 1'b0;
    end
  endtask

  // --------------------
  // stimulus
  initial begin
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_addr      = '0;
    error_count = 0;
    idx         = 0;
    req_seen    = 1'b0;
    ref_rep     = 1'b0;
    for (int s = 0; s < SETS; s++) begin
      ref_valid[s][0] = 1'b0;
      ref_valid[s][1] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    #(SAMPLE_DELAY);
    compare("o_rd_req", o_rd_req, 1'b0);
    compare("o_data_ok", o_data_ok, 1'b0);

    while (idx < NUM_REQS || pend_q.size() != 0) begin
      @(negedge i_clk);
      if (idx < NUM_REQS) begin
        i_valid = 1'b1;
        i_addr  = req_table[idx];  // held until accepted
      end else begin
        i_valid = 1'b0;
        i_addr  = '0;
      end
      #(SAMPLE_DELAY);
      if (o_rd_req) begin
        check_request();
      end
      if (o_data_ok) begin
        check_response();  // before the next acceptance
      end
      if (i_valid && o_addr_ok) begin
        accept_request(i_addr);
        idx++;
      end
    end

    repeat (4) begin
      @(negedge i_clk);
      #(SAMPLE_DELAY);
      compare("o_data_ok", o_data_ok, 1'b0);  // no stray response
      compare("o_rd_req", o_rd_req, 1'b0);
    end
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
